// ==== dv/snd_board_tb.sv ====
// directed testbench that plays host cpu, sound cpu and rom around the audio section top
`timescale 1ns/1ps

module snd_board_tb;

    localparam int MAX_CYCLES = 6000;  // run limit in clock cycles

    logic                  clk;
    logic                  rst_n;
    snd_pkg::apb_req_t     apb;
    snd_pkg::snd_bus_req_t bus;
    logic [7:0]            rom_data;
    logic                  rom_ok;
    snd_pkg::apb_rsp_t     apb_rsp;
    logic                  nmi_n;
    logic [7:0]            rdata;
    logic                  bus_wait;
    logic [14:0]           rom_addr;
    logic                  rom_cs;
    logic signed [15:0]    left;
    logic signed [15:0]    right;
    logic                  sample;

    logic [19:0] lfsr;       // x^20 + x^17 + 1
    logic [2:0]  rom_delay;
    logic        rom_armed;  // delay already drawn for this rom cycle
    int          n_checks;
    int          n_errors;
    int          cycles;

    snd_board UUT (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // one lfsr step per bit taken, newest bit lowest
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[19] ^ lfsr[16];
            lfsr = {lfsr[18:0], fb};
            r    = {r[14:0], fb};
        end
        return r;
    endfunction

    // rom model answering 0 to 7 cycles after rom_cs with the low address byte xor 5a
    always @(negedge clk) begin
        if (!rom_cs) begin
            rom_ok    = 1'b0;
            rom_armed = 1'b0;
        end else begin
            if (!rom_armed) begin
                rom_delay = 3'(rand_bits(3));
                rom_armed = 1'b1;
            end else if (rom_delay != 3'd0)
                rom_delay = rom_delay - 3'd1;
            if (rom_delay == 3'd0) begin
                rom_ok   = 1'b1;
                rom_data = rom_addr[7:0] ^ 8'h5A;
            end
        end
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("[ERROR] %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [7:0] data);
        @(negedge clk);
        apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(negedge clk);
        apb.penable = 1'b1;  // write lands on the next edge
        @(negedge clk);
        check(apb_rsp.pready, 1'b1, "pready on write");
        apb = '0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [7:0] data, output logic err);
        @(negedge clk);
        apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 8'h00};
        @(negedge clk);
        apb.penable = 1'b1;
        @(negedge clk);
        data = apb_rsp.prdata;  // still in the access phase
        err  = apb_rsp.pslverr;
        check(apb_rsp.pready, 1'b1, "pready on read");
        apb  = '0;
    endtask

    // one sound cpu cycle held until wait is seen low
    task automatic bus_cycle(input logic is_mem, input logic is_wr, input logic [15:0] addr,
                             input logic [7:0] wdata, output logic [7:0] data);
        int waits;
        @(negedge clk);
        bus = '{mreq: is_mem, iorq: !is_mem, rd: !is_wr, wr: is_wr, addr: addr, wdata: wdata};
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (bus_wait);
        data = rdata;
        if (!(is_mem && !addr[15]))
            check(waits, 2, "wait cycles of a non-rom access");
        @(negedge clk);  // drop after the edge that sees wait low
        bus = '0;
    endtask

    task automatic mem_read(input logic [15:0] addr, output logic [7:0] data);
        bus_cycle(1'b1, 1'b0, addr, 8'h00, data);
    endtask

    task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        bus_cycle(1'b1, 1'b1, addr, data, unused);
    endtask

    task automatic io_read(input logic [15:0] port, output logic [7:0] data);
        bus_cycle(1'b0, 1'b0, port, 8'h00, data);
    endtask

    task automatic io_write(input logic [15:0] port, input logic [7:0] data);
        logic [7:0] unused;
        bus_cycle(1'b0, 1'b1, port, data, unused);
    endtask

    // clocks since the previous strobe come back in gap
    task automatic wait_strobe(output int gap);
        gap = 0;
        do begin
            @(negedge clk);
            gap++;
        end while (!sample);
    endtask

    task automatic rom_reads();
        logic [15:0] addr;
        logic [7:0]  data;
        repeat (8) begin
            addr = rand_bits(15);  // bit 15 low
            mem_read(addr, data);
            check(data, addr[7:0] ^ 8'h5A, "rom read data");
        end
    endtask

    task automatic ram_and_open_bus();
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic [7:0]  data;
        repeat (8) begin
            addr  = 16'hF800 | rand_bits(11);
            wdata = 8'(rand_bits(8));
            mem_write(addr, wdata);
            mem_read(addr, data);
            check(data, wdata, "ram readback");
        end
        mem_read(16'h9000, data);
        check(data, 8'hFF, "unmapped memory read");
        io_read(16'h0080, data);
        check(data, 8'hFF, "unmapped port read");
    endtask

    // command through the latch and back out on the sound side
    task automatic latch_and_nmi(input logic via_mem, input logic [7:0] cmd);
        logic [7:0] data;
        logic       err;
        apb_write(4'h0, cmd);
        check(nmi_n, 1'b0, "nmi_n after latch write");
        apb_read(4'h4, data, err);
        check(err, 1'b0, "pslverr on status");
        check(data, 8'h01, "status with command pending");
        if (via_mem)
            mem_read(16'hE800, data);
        else
            io_read(16'h00C0, data);
        check(data, cmd, "latch byte on the sound bus");
        check(nmi_n, 1'b1, "nmi_n after latch read");
        apb_read(4'h4, data, err);
        check(err, 1'b0, "pslverr on status");
        check(data, 8'h00, "status after latch read");
    endtask

    task automatic apb_errors_and_cfg();
        logic [7:0] data;
        logic       err;
        apb_read(4'hC, data, err);
        check(err, 1'b1, "pslverr on address c");
        apb_write(4'h8, 8'h02);
        apb_read(4'h8, data, err);
        check(err, 1'b0, "pslverr on cfg");
        check(data, 8'h02, "cfg readback");
        apb_write(4'h8, 8'h00);
    endtask

    task automatic tone_outputs();
        logic [7:0]         tone_regs [4];
        logic [7:0]         data;
        logic signed [15:0] prev;
        logic signed [15:0] lvl;
        int                 run;
        int                 gap;
        tone_regs[0] = 8'h03;  // ch0 period 3
        tone_regs[1] = 8'h20;  // ch0 volume 2
        tone_regs[2] = 8'h00;  // ch1 period 0 holds polarity
        tone_regs[3] = 8'h50;  // ch1 volume 5
        for (int i = 0; i < 4; i++)
            io_write(16'(i), tone_regs[i]);
        for (int i = 0; i < 4; i++) begin
            io_read(16'(i), data);
            check(data, tone_regs[i], "tone register readback");
        end
        wait_strobe(gap);  // first strobe with the full setup
        prev = left;
        do
            wait_strobe(gap);
        while (left == prev);  // lock onto a polarity flip
        lvl = left;
        check(lvl == 1024 || lvl == -1024, 1'b1, "ch0 amplitude, 2 steps of 512");
        run = 1;
        repeat (9) begin
            wait_strobe(gap);
            check(gap, 16, "clocks between sample strobes");
            if (run == 3) begin
                lvl = -lvl;
                run = 0;
            end
            run++;
            check(left, lvl, "square wave on left");
            check(right, 2560, "ch1 level on right");
        end
        apb_write(4'h8, 8'h02);  // swap
        wait_strobe(gap);
        check(left, 2560, "ch1 on left with swap");
        check(right == 1024 || right == -1024, 1'b1, "ch0 on right with swap");
        apb_write(4'h8, 8'h01);  // mute
        wait_strobe(gap);
        check(left, 0, "left muted");
        check(right, 0, "right muted");
        apb_write(4'h8, 8'h00);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        apb       = '0;
        bus       = '0;
        rom_data  = 8'h00;
        rom_ok    = 1'b0;
        rom_armed = 1'b0;
        rom_delay = 3'd0;
        lfsr      = 20'd99268;
        n_checks  = 0;
        n_errors  = 0;
        cycles    = 0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check(nmi_n, 1'b1, "nmi_n after reset");
        rom_reads();
        ram_and_open_bus();
        latch_and_nmi(1'b0, 8'(rand_bits(8)));
        latch_and_nmi(1'b1, 8'(rand_bits(8)));
        apb_errors_and_cfg();
        tone_outputs();
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the sound board testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f snd_board.f \
        --top-module snd_board_tb -o snd_board_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/snd_board_sim)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

// ==== snd_board.f ====
source/snd_pkg.sv
source/snd_host_regs.sv
source/snd_bus_decode.sv
source/snd_ram.sv
source/snd_tone.sv
source/snd_board.sv
dv/snd_board_tb.sv

// ==== source/snd_board.sv ====
// audio section top: host registers, sound bus decoder, work ram and tone generator
`timescale 1ns/1ps

module snd_board (
    input  logic                  clk,
    input  logic                  rst_n,
    input  snd_pkg::apb_req_t     apb,
    input  snd_pkg::snd_bus_req_t bus,
    input  logic [7:0]            rom_data,
    input  logic                  rom_ok,
    output snd_pkg::apb_rsp_t     apb_rsp,
    output logic                  nmi_n,
    output logic [7:0]            rdata,
    output logic                  bus_wait,
    output logic [14:0]           rom_addr,
    output logic                  rom_cs,
    output logic signed [15:0]    left,
    output logic signed [15:0]    right,
    output logic                  sample
);

    logic [7:0]                 latch;
    logic                       latch_rd;
    snd_pkg::snd_cfg_t          cfg;
    logic                       ram_we;
    logic [snd_pkg::RAM_AW-1:0] ram_addr;
    logic [7:0]                 ram_wdata;
    logic [7:0]                 ram_rdata;
    snd_pkg::tone_wr_t          tone_wr;
    logic [7:0]                 tone_rdata;

    // main cpu side
    snd_host_regs u_host (
        .clk      (clk),
        .rst_n    (rst_n),
        .apb      (apb),
        .latch_rd (latch_rd),
        .apb_rsp  (apb_rsp),
        .latch    (latch),
        .nmi_n    (nmi_n),
        .cfg      (cfg)
    );

    snd_bus_decode u_dec (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus        (bus),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .ram_rdata  (ram_rdata),
        .latch      (latch),
        .tone_rdata (tone_rdata),
        .rdata      (rdata),
        .bus_wait   (bus_wait),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .tone_wr    (tone_wr),
        .latch_rd   (latch_rd)
    );

    snd_ram u_ram (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    // readback index straight from the port number
    snd_tone u_tone (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (tone_wr),
        .cfg      (cfg),
        .rd_index (bus.addr[2:0]),
        .rdata    (tone_rdata),
        .left     (left),
        .right    (right),
        .sample   (sample)
    );

endmodule

// ==== source/snd_bus_decode.sv ====
// sound cpu bus decoder: address map, rom wait states, registered read mux and block strobes
`timescale 1ns/1ps

module snd_bus_decode (
    input  logic                        clk,
    input  logic                        rst_n,
    input  snd_pkg::snd_bus_req_t       bus,
    input  logic [7:0]                  rom_data,
    input  logic                        rom_ok,
    input  logic [7:0]                  ram_rdata,
    input  logic [7:0]                  latch,
    input  logic [7:0]                  tone_rdata,
    output logic [7:0]                  rdata,
    output logic                        bus_wait,
    output logic [14:0]                 rom_addr,
    output logic                        rom_cs,
    output logic                        ram_we,
    output logic [snd_pkg::RAM_AW-1:0]  ram_addr,
    output logic [7:0]                  ram_wdata,
    output snd_pkg::tone_wr_t           tone_wr,
    output logic                        latch_rd
);

    typedef enum logic [1:0] {ST_IDLE, ST_SEL, ST_ROM, ST_END} state_t;

    state_t     state;
    logic       req;
    logic       rom_hit, ram_hit, tone_hit, latch_hit;
    logic       ram_cs, tone_cs, latch_cs;
    logic       rom_ok2;     // rom_ok one cycle back
    logic       rom_good;
    logic       last;        // wait-low cycle
    logic       mux_en;
    logic [7:0] rd_mux;

    assign req = (bus.mreq | bus.iorq) & (bus.rd | bus.wr);

    // address map, io ports decode on the low byte
    assign rom_hit   = bus.mreq & (bus.addr <= snd_pkg::ROM_TOP);
    assign ram_hit   = bus.mreq & (bus.addr >= snd_pkg::RAM_BASE);
    assign tone_hit  = bus.iorq & (bus.addr[7:6] == snd_pkg::IO_TONE);
    assign latch_hit = (bus.mreq & (bus.addr[15:11] == snd_pkg::LATCH_MEM[15:11]))
                     | (bus.iorq & (bus.addr[7:6] == snd_pkg::IO_LATCH));

    assign last     = state == ST_END;
    assign bus_wait = req & ~last;
    assign rom_good = rom_cs & rom_ok & rom_ok2;  // two ok cycles in a row
    assign mux_en   = (state == ST_SEL) | ((state == ST_ROM) & rom_good);

    assign rom_addr  = bus.addr[14:0];
    assign ram_addr  = bus.addr[snd_pkg::RAM_AW-1:0];
    assign ram_wdata = bus.wdata;
    assign ram_we    = last & ram_cs & bus.wr;  // once, on wait low

    assign tone_wr.strobe = last & tone_cs & bus.wr;
    assign tone_wr.idx    = bus.addr[2:0];
    assign tone_wr.data   = bus.wdata;
    assign latch_rd       = last & latch_cs & bus.rd;  // clears the pending nmi

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            rom_cs   <= 1'b0;
            ram_cs   <= 1'b0;
            tone_cs  <= 1'b0;
            latch_cs <= 1'b0;
            rom_ok2  <= 1'b0;
        end else begin
            rom_ok2 <= rom_cs & rom_ok;
            case (state)
                ST_IDLE: if (req) begin
                    rom_cs   <= rom_hit;  // held for the whole rom cycle
                    ram_cs   <= ram_hit;
                    tone_cs  <= tone_hit;
                    latch_cs <= latch_hit;
                    state    <= rom_hit ? ST_ROM : ST_SEL;
                end
                ST_SEL: state <= ST_END;  // mux registered here
                ST_ROM: if (rom_good) state <= ST_END;
                default: begin            // end of cycle, drop selects
                    rom_cs   <= 1'b0;
                    ram_cs   <= 1'b0;
                    tone_cs  <= 1'b0;
                    latch_cs <= 1'b0;
                    state    <= ST_IDLE;
                end
            endcase
        end
    end

    // priority read mux
    assign rd_mux = rom_cs   ? rom_data   :
                    ram_cs   ? ram_rdata  :
                    tone_cs  ? tone_rdata :
                    latch_cs ? latch      : snd_pkg::OPEN_BUS;

    always_ff @(posedge clk) begin
        if (mux_en)
            rdata <= rd_mux;
    end

    a_rom_cs_mreq: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rom_cs) |-> bus.mreq)
        else $error("rom_cs rose without mreq");

    // master must hold the request through the wait
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_wait && $past(bus_wait)) |-> $stable(bus))
        else $error("bus request changed during wait");

endmodule

// ==== source/snd_host_regs.sv ====
// host apb register block with the sound latch, the pending nmi flag and the mute and swap bits
`timescale 1ns/1ps

module snd_host_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  snd_pkg::apb_req_t apb,
    input  logic              latch_rd,  // sound cpu read the latch
    output snd_pkg::apb_rsp_t apb_rsp,
    output logic [7:0]        latch,
    output logic              nmi_n,
    output snd_pkg::snd_cfg_t cfg
);

    logic access;       // apb access phase
    logic wr_en;
    logic latch_wr;
    logic mapped;
    logic pending;
    logic pending_nxt;

    assign access   = apb.psel & apb.penable;
    assign wr_en    = access & apb.pwrite;
    assign latch_wr = wr_en & (apb.paddr == snd_pkg::REG_LATCH);

    always_comb begin
        mapped = (apb.paddr == snd_pkg::REG_LATCH) ||
                 (apb.paddr == snd_pkg::REG_STATUS) ||
                 (apb.paddr == snd_pkg::REG_CFG);
    end

    // a new command beats the clear from the sound side
    always_comb begin
        pending_nxt = pending;
        if (latch_wr)
            pending_nxt = 1'b1;
        else if (latch_rd)
            pending_nxt = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
            nmi_n   <= 1'b1;
            cfg     <= '0;
        end else begin
            pending <= pending_nxt;
            nmi_n   <= ~pending_nxt;  // low while a command waits
            if (wr_en && apb.paddr == snd_pkg::REG_CFG)
                cfg <= snd_pkg::snd_cfg_t'(apb.pwdata[1:0]);
        end
    end

    // command byte itself
    always_ff @(posedge clk) begin
        if (latch_wr)
            latch <= apb.pwdata;
    end

    // read data valid in the access cycle
    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access & ~mapped;
        case (apb.paddr)
            snd_pkg::REG_STATUS: apb_rsp.prdata = {7'd0, pending};
            snd_pkg::REG_CFG:    apb_rsp.prdata = {6'd0, cfg};
            default:             apb_rsp.prdata = 8'h00;  // latch is write only
        endcase
    end

    // new command pulls nmi low on the next cycle
    a_nmi_set: assert property (@(posedge clk) disable iff (!rst_n)
        latch_wr |=> !nmi_n)
        else $error("nmi_n not low after latch write");

    // a latch read without a new command releases nmi
    a_nmi_clear: assert property (@(posedge clk) disable iff (!rst_n)
        (latch_rd && !latch_wr) |=> nmi_n)
        else $error("nmi_n not released after latch read");

endmodule

// ==== source/snd_pkg.sv ====
// shared bus structs, address map and tone constants for the sound section, used by scoped name
package snd_pkg;

    // one sound cpu bus request, held stable by the master until wait drops
    typedef struct packed {
        logic        mreq;  // memory cycle
        logic        iorq;  // io cycle
        logic        rd;
        logic        wr;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } snd_bus_req_t;

    // host side apb request
    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        logic [3:0] paddr;
        logic [7:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [7:0] prdata;
        logic       pready;   // tied high, no back-pressure on the host side
        logic       pslverr;
    } apb_rsp_t;

    // host configuration, mute lands on bit 0
    typedef struct packed {
        logic swap;  // exchange left and right
        logic mute;  // zero both outputs
    } snd_cfg_t;

    // register write from the decoder into the tone block
    typedef struct packed {
        logic       strobe;
        logic [2:0] idx;
        logic [7:0] data;
    } tone_wr_t;

    // sound cpu memory map
    localparam logic [15:0] ROM_TOP   = 16'h7FFF;  // rom is the lower 32 KB
    localparam logic [15:0] RAM_BASE  = 16'hF800;  // 2 KB work ram up to ffff
    localparam logic [15:0] LATCH_MEM = 16'hE800;  // e800-efff reads the latch

    // io port groups, top two bits of the port number
    localparam logic [1:0] IO_TONE  = 2'd0;
    localparam logic [1:0] IO_LATCH = 2'd3;

    localparam logic [7:0] OPEN_BUS = 8'hFF;  // unmapped read value
    localparam int         RAM_AW   = 11;

    // apb register offsets
    localparam logic [3:0] REG_LATCH  = 4'h0;  // write only
    localparam logic [3:0] REG_STATUS = 4'h4;  // bit 0 pending
    localparam logic [3:0] REG_CFG    = 4'h8;  // bit 0 mute, bit 1 swap

    // tone generator
    localparam int TONE_CH    = 2;
    localparam int TONE_REGS  = 2 * TONE_CH;  // period low, period high and volume per channel
    localparam int PER_W      = 12;           // 8 low bits plus a nibble
    localparam int SAMPLE_DIV = 16;           // clocks per sample tick
    localparam int DIV_W      = $clog2(SAMPLE_DIV);
    localparam int VOL_STEP   = 512;          // amplitude per volume step

endpackage

// ==== source/snd_ram.sv ====
// sound cpu work ram, 2 KB single port with registered read
`timescale 1ns/1ps

module snd_ram (
    input  logic                       clk,
    input  logic                       we,
    input  logic [snd_pkg::RAM_AW-1:0] addr,
    input  logic [7:0]                 wdata,
    output logic [7:0]                 rdata
);

    // contents undefined until written
    logic [7:0] mem [2**snd_pkg::RAM_AW];

    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= wdata;
    end

    // old data on a write cycle
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

// ==== source/snd_tone.sv ====
// two-channel square-wave tone generator and stereo mixer standing in for the fm synth
`timescale 1ns/1ps

module snd_tone (
    input  logic                clk,
    input  logic                rst_n,
    input  snd_pkg::tone_wr_t   wr,
    input  snd_pkg::snd_cfg_t   cfg,
    input  logic [2:0]          rd_index,
    output logic [7:0]          rdata,
    output logic signed [15:0]  left,
    output logic signed [15:0]  right,
    output logic                sample
);

    logic [7:0]                 regs    [snd_pkg::TONE_REGS];
    logic [snd_pkg::DIV_W-1:0]  div_cnt;
    logic                       tick;     // sample strobe on the next edge
    logic [snd_pkg::PER_W-1:0]  period  [snd_pkg::TONE_CH];
    logic [3:0]                 vol     [snd_pkg::TONE_CH];
    logic [snd_pkg::PER_W-1:0]  cnt     [snd_pkg::TONE_CH];
    logic                       neg     [snd_pkg::TONE_CH];  // 0 is positive polarity
    logic                       neg_nxt [snd_pkg::TONE_CH];
    logic signed [15:0]         level   [snd_pkg::TONE_CH];
    logic signed [15:0]         mix_l, mix_r;

    assign tick = div_cnt == snd_pkg::DIV_W'(snd_pkg::SAMPLE_DIV - 1);

    // per channel fields and next level
    always_comb begin
        for (int c = 0; c < snd_pkg::TONE_CH; c++) begin
            period[c]  = {regs[2*c+1][3:0], regs[2*c]};
            vol[c]     = regs[2*c+1][7:4];
            neg_nxt[c] = (period[c] != '0 && cnt[c] == '0) ? ~neg[c] : neg[c];
            level[c]   = 16'(int'(vol[c]) * snd_pkg::VOL_STEP);
            if (neg_nxt[c])
                level[c] = -level[c];
        end
    end

    // stereo mix
    always_comb begin
        mix_l = cfg.swap ? level[1] : level[0];
        mix_r = cfg.swap ? level[0] : level[1];
        if (cfg.mute) begin
            mix_l = '0;
            mix_r = '0;
        end
    end

    assign rdata = (rd_index < snd_pkg::TONE_REGS) ? regs[rd_index[1:0]] : 8'h00;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            sample  <= 1'b0;
            left    <= '0;
            right   <= '0;
            for (int i = 0; i < snd_pkg::TONE_REGS; i++)
                regs[i] <= '0;
            for (int c = 0; c < snd_pkg::TONE_CH; c++) begin
                cnt[c] <= '0;
                neg[c] <= 1'b0;
            end
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            sample  <= tick;
            if (wr.strobe && wr.idx < snd_pkg::TONE_REGS)
                regs[wr.idx[1:0]] <= wr.data;
            if (tick) begin
                for (int c = 0; c < snd_pkg::TONE_CH; c++) begin
                    if (period[c] != '0)  // period 0 freezes the channel
                        cnt[c] <= (cnt[c] == '0) ? period[c] - 1'b1 : cnt[c] - 1'b1;
                    neg[c] <= neg_nxt[c];
                end
                left  <= mix_l;  // outputs change with the strobe
                right <= mix_r;
            end
        end
    end

endmodule
